// File: Makefile
VERILATOR    ?= verilator
TOP          := alu_tb
RTL_TOP      := alu_top
FILELIST     := filelist.f
OBJ_DIR      := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --timescale 1ns/100ps
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
SIM_FLAGS    := --binary $(COMMON_FLAGS) -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/alu_common.sv
package alu_common;

  // ==============================
  // Operation codes
  // ==============================

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOT,
    ALU_NOP0,
    ALU_NOP1
  } alu_op_t;

  // ==============================
  // Slice geometry
  // ==============================

  localparam int SLICE_WIDTH = 4;      // Nibble width of one slice.
  localparam int SLICE_OUT_WIDTH = 8;

  // Bit positions inside the byte that a slice returns.
  localparam int OUT_RESULT_LSB = 0;
  localparam int OUT_RESULT_MSB = SLICE_WIDTH - 1;
  localparam int OUT_PROP = 4;
  localparam int OUT_GEN = 5;
  localparam int OUT_ZERO = 6;
  localparam int OUT_SPARE = 7;        // Always reads as 0.

  // True for the two operations that use the carry chain.
  function automatic logic is_arith(alu_op_t op);
    return (op == ALU_ADD) || (op == ALU_SUB);
  endfunction

endpackage

// File: design/alu_datapath.sv
module alu_datapath import alu_common::*, status_common::*; #(
  parameter int n_slices = 4
) (
  input  alu_op_t                            op,
  input  logic [n_slices*SLICE_WIDTH-1:0]    a,
  input  logic [n_slices*SLICE_WIDTH-1:0]    b,
  input  logic                               carry_in,
  output logic [n_slices*SLICE_WIDTH-1:0]    result_next,
  output status_t                            status_next
);

  localparam int word_width = n_slices * SLICE_WIDTH;
  localparam int msb = word_width - 1;

  logic [n_slices-1:0] prop;
  logic [n_slices-1:0] gen;
  logic [n_slices-1:0] slice_zero;
  logic [n_slices-1:0] slice_c_in;
  logic                carry_out;

  // ==============================
  // Slices and carry chain
  // ==============================

  for (genvar i = 0; i < n_slices; i++) begin : g_slice
    logic [SLICE_OUT_WIDTH-1:0] slice_out;

    alu_slice u_slice (
      .A    (a[i*SLICE_WIDTH +: SLICE_WIDTH]),
      .B    (b[i*SLICE_WIDTH +: SLICE_WIDTH]),
      .OP   (op),
      .C_IN (slice_c_in[i]),
      .OUT  (slice_out)
    );

    assign result_next[i*SLICE_WIDTH +: SLICE_WIDTH] =
      slice_out[OUT_RESULT_MSB:OUT_RESULT_LSB];
    assign prop[i] = slice_out[OUT_PROP];
    assign gen[i] = slice_out[OUT_GEN];
    assign slice_zero[i] = slice_out[OUT_ZERO];
  end

  carry_lookahead #(
    .n_slices (n_slices)
  ) u_lookahead (
    .prop       (prop),
    .gen        (gen),
    .subtract   (op == ALU_SUB),
    .carry_in   (carry_in),
    .slice_c_in (slice_c_in),
    .carry_out  (carry_out)
  );

  // ==============================
  // Flags
  // ==============================

  always_comb begin
    status_next = STATUS_RESET;
    status_next.zero = &slice_zero;
    status_next.negative = result_next[msb];
    case (op)
      ALU_ADD: begin
        status_next.carry = carry_out;
        status_next.overflow = (a[msb] == b[msb]) && (result_next[msb] != a[msb]);
      end
      ALU_SUB: begin
        status_next.carry = carry_out;  // Already the borrow out.
        status_next.overflow = (a[msb] != b[msb]) && (result_next[msb] != a[msb]);
      end
      default: ;  // Logic ops and NOPs leave carry and overflow clear.
    endcase
  end

endmodule

// File: design/alu_sequencer.sv
module alu_sequencer import alu_common::*, status_common::*; #(
  parameter int n_slices = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req,
  input  alu_op_t                         op,
  input  logic [n_slices*SLICE_WIDTH-1:0] a,
  input  logic [n_slices*SLICE_WIDTH-1:0] b,
  input  logic                            use_carry,
  output logic                            ack,
  output logic [n_slices*SLICE_WIDTH-1:0] result,
  output status_t                         status,
  output alu_op_t                         dp_op,
  output logic [n_slices*SLICE_WIDTH-1:0] dp_a,
  output logic [n_slices*SLICE_WIDTH-1:0] dp_b,
  output logic                            dp_carry_in,
  input  logic [n_slices*SLICE_WIDTH-1:0] result_next,
  input  status_t                         status_next
);

  localparam int word_width = n_slices * SLICE_WIDTH;

  typedef enum logic [1:0] {
    IDLE,
    EXECUTE,
    DONE
  } state_t;

  state_t state;
  logic   start;

  assign start = (state == IDLE) && req;

  // ==============================
  // Handshake FSM
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      ack <= 1'b0;
      result <= {word_width{1'b0}};
      status <= STATUS_RESET;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= EXECUTE;
          end
        end
        EXECUTE: begin
          result <= result_next;  // Datapath has had a full cycle to settle.
          status <= status_next;
          ack <= 1'b1;
          state <= DONE;
        end
        DONE: begin
          // Result and status hold for as long as req stays high.
          if (!req) begin
            ack <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operands are captured once per request.
  always_ff @(posedge clk) begin
    if (start) begin
      dp_op <= op;
      dp_a <= a;
      dp_b <= b;
      dp_carry_in <= use_carry && is_arith(op) && status.carry;
    end
  end

endmodule

// File: design/alu_slice.sv
module alu_slice import alu_common::*; (
  input  logic [SLICE_WIDTH-1:0]     A,
  input  logic [SLICE_WIDTH-1:0]     B,
  input  alu_op_t                    OP,
  input  logic                       C_IN,
  output logic [SLICE_OUT_WIDTH-1:0] OUT
);

  logic [SLICE_WIDTH-1:0] out_low;
  logic [SLICE_WIDTH-1:0] b_eff;
  logic [SLICE_WIDTH:0]   raw_sum;  // Sum without C_IN. Its extra top bit is gen.
  logic                   prop;
  logic                   gen;

  // SUB runs the carry chain on A + ~B, so prop and gen come from the same adder.
  assign b_eff = (OP == ALU_SUB) ? ~B : B;
  assign raw_sum = {1'b0, A} + {1'b0, b_eff};

  always_comb begin
    prop = 1'b0;
    gen = 1'b0;
    out_low = '0;
    case (OP)
      ALU_ADD: begin
        out_low = A + B + {{(SLICE_WIDTH-1){1'b0}}, C_IN};  // C_IN is a carry.
        prop = &raw_sum[SLICE_WIDTH-1:0];
        gen = raw_sum[SLICE_WIDTH];
      end
      ALU_SUB: begin
        out_low = A - B - {{(SLICE_WIDTH-1){1'b0}}, C_IN};  // C_IN is a borrow.
        prop = &raw_sum[SLICE_WIDTH-1:0];
        gen = raw_sum[SLICE_WIDTH];
      end
      ALU_AND:  out_low = A & B;
      ALU_OR:   out_low = A | B;
      ALU_XOR:  out_low = A ^ B;
      ALU_NOT:  out_low = ~A;
      ALU_NOP0: out_low = '0;
      ALU_NOP1: out_low = '0;
      default:  out_low = '0;
    endcase
  end

  always_comb begin
    OUT = '0;
    OUT[OUT_RESULT_MSB:OUT_RESULT_LSB] = out_low;
    OUT[OUT_PROP] = prop;
    OUT[OUT_GEN] = gen;
    OUT[OUT_ZERO] = (out_low == '0);
    OUT[OUT_SPARE] = 1'b0;
  end

endmodule

// File: design/alu_top.sv
module alu_top import alu_common::*, status_common::*; #(
  parameter int n_slices = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req,
  input  alu_op_t                         op,
  input  logic [n_slices*SLICE_WIDTH-1:0] a,
  input  logic [n_slices*SLICE_WIDTH-1:0] b,
  input  logic                            use_carry,
  output logic                            ack,
  output logic [n_slices*SLICE_WIDTH-1:0] result,
  output status_t                         status
);

  localparam int word_width = n_slices * SLICE_WIDTH;

  alu_op_t               dp_op;
  logic [word_width-1:0] dp_a;
  logic [word_width-1:0] dp_b;
  logic                  dp_carry_in;
  logic [word_width-1:0] result_next;
  status_t               status_next;

  alu_sequencer #(
    .n_slices (n_slices)
  ) u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .op          (op),
    .a           (a),
    .b           (b),
    .use_carry   (use_carry),
    .ack         (ack),
    .result      (result),
    .status      (status),
    .dp_op       (dp_op),
    .dp_a        (dp_a),
    .dp_b        (dp_b),
    .dp_carry_in (dp_carry_in),
    .result_next (result_next),
    .status_next (status_next)
  );

  alu_datapath #(
    .n_slices (n_slices)
  ) u_datapath (
    .op          (dp_op),
    .a           (dp_a),
    .b           (dp_b),
    .carry_in    (dp_carry_in),
    .result_next (result_next),
    .status_next (status_next)
  );

endmodule

// File: design/carry_lookahead.sv
module carry_lookahead #(
  parameter int n_slices = 4
) (
  input  logic [n_slices-1:0] prop,
  input  logic [n_slices-1:0] gen,
  input  logic                subtract,
  input  logic                carry_in,
  output logic [n_slices-1:0] slice_c_in,
  output logic                carry_out
);

  logic                carry_0;
  logic [n_slices:0]   carry;   // carry[i] is the carry into slice i.

  // A borrow in is the inverse of a carry in.
  assign carry_0 = subtract ? ~carry_in : carry_in;

  // Each carry is a flat sum of products over the slices below it, so no
  // slice waits on the one beneath it.
  always_comb begin : p_lookahead
    logic chain;
    logic acc;
    carry[0] = carry_0;
    for (int i = 1; i <= n_slices; i++) begin
      chain = 1'b1;
      acc = 1'b0;
      for (int j = i - 1; j >= 0; j--) begin
        acc = acc | (chain & gen[j]);
        chain = chain & prop[j];
      end
      carry[i] = acc | (chain & carry_0);
    end
  end

  // Back to borrow polarity for SUB.
  assign slice_c_in = subtract ? ~carry[n_slices-1:0] : carry[n_slices-1:0];
  assign carry_out = subtract ? ~carry[n_slices] : carry[n_slices];

endmodule

// File: design/status_common.sv
package status_common;

  // ==============================
  // Status register
  // ==============================

  // For SUB the carry field holds the borrow out of the top slice.
  typedef struct packed {
    logic carry;
    logic zero;
    logic negative;
    logic overflow;
  } status_t;

  localparam status_t STATUS_RESET = '{
    carry:    1'b0,
    zero:     1'b0,
    negative: 1'b0,
    overflow: 1'b0
  };

endpackage

// File: filelist.f
design/alu_common.sv
design/status_common.sv
design/alu_slice.sv
design/carry_lookahead.sv
design/alu_datapath.sv
design/alu_sequencer.sv
design/alu_top.sv
tests/tb_clock.sv
tests/alu_tb.sv

// File: tests/alu_tb.sv
module alu_tb import alu_common::*, status_common::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_slices = 4;
  localparam int word_width = n_slices * SLICE_WIDTH;
  localparam int msb = word_width - 1;
  localparam int n_arith = 200;
  localparam int n_logic = 100;
  localparam int n_chain = 8;
  localparam int ack_wait_limit = 8;
  // Roughly 880 operations at up to six cycles each, with margin on top.
  localparam int max_cycles = (2 * n_arith + 4 * n_logic + 80) * 6 + 720;

  typedef logic [word_width-1:0] word_t;

  logic    clk;
  logic    reset;
  logic    req;
  alu_op_t op;
  word_t   a;
  word_t   b;
  logic    use_carry;
  logic    ack;
  word_t   result;
  status_t status;

  int          check_count = 0;
  int          mismatch_count = 0;
  int          fail_count = 0;
  int          cycle_count = 0;
  logic        model_carry = 1'b0;   // The model's own copy of the carry flag.
  logic [31:0] rng_state = 32'hede14a01;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  alu_top #(
    .n_slices (n_slices)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .op        (op),
    .a         (a),
    .b         (b),
    .use_carry (use_carry),
    .ack       (ack),
    .result    (result),
    .status    (status)
  );

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_result(input string name, input word_t expected, input word_t actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s expected 0x%h got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_status(input string name, input status_t expected, input status_t actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s expected 0x%h got 0x%h", name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s expected 0x%h got 0x%h", name, expected, actual);
    end
  endtask

  task automatic compare_latency(input string name, input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
      mismatch_count++;
      $display("mismatch %s expected 0x%h got 0x%h", name, expected, actual);
    end
  endtask

  // ==============================
  // Reference model and stimulus
  // ==============================

  function automatic void model_op(input alu_op_t op_i, input word_t a_i, input word_t b_i,
                                   input logic use_c, output word_t res, output status_t st);
    logic [word_width:0] wide;
    logic                cin;
    cin = use_c & model_carry;
    wide = '0;
    st = STATUS_RESET;
    case (op_i)
      ALU_ADD: begin
        wide = {1'b0, a_i} + {1'b0, b_i} + {{word_width{1'b0}}, cin};
        st.carry = wide[word_width];
        st.overflow = (a_i[msb] == b_i[msb]) && (wide[msb] != a_i[msb]);
      end
      ALU_SUB: begin
        wide = {1'b0, a_i} - {1'b0, b_i} - {{word_width{1'b0}}, cin};
        st.carry = wide[word_width];  // Borrow out of the top bit.
        st.overflow = (a_i[msb] != b_i[msb]) && (wide[msb] != a_i[msb]);
      end
      ALU_AND: wide = {1'b0, a_i & b_i};
      ALU_OR:  wide = {1'b0, a_i | b_i};
      ALU_XOR: wide = {1'b0, a_i ^ b_i};
      ALU_NOT: wide = {1'b0, ~a_i};
      default: wide = '0;
    endcase
    res = wide[msb:0];
    st.zero = (res == '0);
    st.negative = res[msb];
    model_carry = st.carry;
  endfunction

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic word_t rand_word();
    logic [31:0] r;
    r = lcg_next();
    return r[31:32-word_width];  // Upper bits of an LCG are the better ones.
  endfunction

  // One full four-phase transfer. The request is held for hold extra cycles after ack.
  task automatic run_op(input alu_op_t op_i, input word_t a_i, input word_t b_i,
                        input logic use_c, input int hold,
                        output word_t res_o, output status_t st_o);
    word_t   exp_res;
    status_t exp_st;
    int      edges;
    model_op(op_i, a_i, b_i, use_c, exp_res, exp_st);
    @(posedge clk);
    req <= 1'b1;
    op <= op_i;
    a <= a_i;
    b <= b_i;
    use_carry <= use_c;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ack && edges < ack_wait_limit);
    if (!ack) begin
      fail_count++;
      $display("ack did not rise within %0d cycles of req for op %s", edges, op_i.name());
    end else begin
      compare_latency("ack_rise_edges", 2, edges);
      check_result("result", exp_res, result);
      check_status("status", exp_st, status);
      repeat (hold) begin
        @(negedge clk);
        compare_bit("held_ack", 1'b1, ack);
        check_result("held_result", exp_res, result);
        check_status("held_status", exp_st, status);
      end
    end
    res_o = result;
    st_o = status;
    @(posedge clk);
    req <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (ack && edges < ack_wait_limit);
    if (ack) begin
      fail_count++;
      $display("ack stayed high for %0d cycles after req was dropped", edges);
    end else begin
      compare_latency("ack_fall_edges", 1, edges);
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================

  task automatic idle_after_reset();
    repeat (3) begin
      @(negedge clk);
      compare_bit("ack", 1'b0, ack);
      check_result("result", '0, result);
      check_status("status", STATUS_RESET, status);
    end
  endtask

  task automatic add_sub_cases();
    word_t   res;
    status_t st;
    word_t   x;
    word_t   y;
    run_op(ALU_ADD, 16'h0000, 16'h0000, 1'b0, 0, res, st);
    run_op(ALU_ADD, 16'hffff, 16'h0001, 1'b0, 0, res, st);
    run_op(ALU_SUB, 16'h0000, 16'h0001, 1'b0, 0, res, st);
    run_op(ALU_SUB, 16'h8000, 16'h0001, 1'b0, 0, res, st);
    run_op(ALU_ADD, 16'h7fff, 16'h0001, 1'b0, 0, res, st);
    for (int i = 0; i < n_arith; i++) begin
      x = rand_word();
      y = rand_word();
      run_op(ALU_ADD, x, y, 1'b0, 0, res, st);
      x = rand_word();
      y = rand_word();
      run_op(ALU_SUB, x, y, 1'b0, 0, res, st);
    end
  endtask

  // Low word first without carry, then the high word through the stored carry.
  task automatic wide_op(input alu_op_t op_i, input logic [2*word_width-1:0] x,
                         input logic [2*word_width-1:0] y);
    logic [2*word_width:0] expected;
    word_t                 lo;
    word_t                 hi;
    status_t               st_lo;
    status_t               st_hi;
    if (op_i == ALU_SUB) begin
      expected = {1'b0, x} - {1'b0, y};
    end else begin
      expected = {1'b0, x} + {1'b0, y};
    end
    run_op(op_i, x[msb:0], y[msb:0], 1'b0, 0, lo, st_lo);
    run_op(op_i, x[2*word_width-1:word_width], y[2*word_width-1:word_width], 1'b1, 0,
           hi, st_hi);
    check_result("wide_low", expected[msb:0], lo);
    check_result("wide_high", expected[2*word_width-1:word_width], hi);
    compare_bit("wide_carry", expected[2*word_width], st_hi.carry);
  endtask

  task automatic multiword_chain();
    word_t   res;
    status_t st;
    wide_op(ALU_ADD, 32'h0000ffff, 32'h00000001);
    wide_op(ALU_SUB, 32'h00010000, 32'h00000001);
    wide_op(ALU_SUB, 32'h00000000, 32'h00000001);
    for (int i = 0; i < n_chain; i++) begin
      wide_op(ALU_ADD, lcg_next(), lcg_next());
      wide_op(ALU_SUB, lcg_next(), lcg_next());
    end
    // Carry is set here, and the AND below must ignore it.
    run_op(ALU_ADD, 16'hffff, 16'h0001, 1'b0, 0, res, st);
    run_op(ALU_AND, 16'hf0f0, 16'hff00, 1'b1, 0, res, st);
    check_result("and_with_carry", 16'hf000, res);
  endtask

  task automatic bitwise_cases();
    alu_op_t     ops[4];
    word_t       res;
    status_t     st;
    word_t       x;
    word_t       y;
    logic [31:0] r;
    ops[0] = ALU_AND;
    ops[1] = ALU_OR;
    ops[2] = ALU_XOR;
    ops[3] = ALU_NOT;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < n_logic; i++) begin
        x = rand_word();
        y = rand_word();
        r = lcg_next();
        run_op(ops[k], x, y, r[0], 0, res, st);
        compare_bit("logic_carry", 1'b0, st.carry);
        compare_bit("logic_overflow", 1'b0, st.overflow);
      end
    end
    run_op(ALU_NOP0, rand_word(), rand_word(), 1'b0, 0, res, st);
    check_result("nop0_result", '0, res);
    compare_bit("nop0_zero", 1'b1, st.zero);
    run_op(ALU_NOP1, rand_word(), rand_word(), 1'b1, 0, res, st);
    check_result("nop1_result", '0, res);
    compare_bit("nop1_zero", 1'b1, st.zero);
  endtask

  task automatic held_request();
    word_t   res;
    status_t st;
    run_op(ALU_ADD, 16'hffff, 16'h0001, 1'b0, 10, res, st);
    compare_bit("held_carry", 1'b1, st.carry);
    run_op(ALU_ADD, 16'h0000, 16'h0000, 1'b1, 0, res, st);
    check_result("carry_after_hold", 16'h0001, res);  // One carry, not two.
    run_op(ALU_ADD, 16'h0000, 16'h0000, 1'b1, 0, res, st);
    check_result("carry_consumed", 16'h0000, res);
  endtask

  // ==============================
  // Watchdog and main sequence
  // ==============================

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish.", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    req = 1'b0;
    op = ALU_NOP0;
    a = '0;
    b = '0;
    use_carry = 1'b0;
    @(negedge clk);
    while (reset) @(negedge clk);
    idle_after_reset();
    add_sub_cases();
    multiword_chain();
    bitwise_cases();
    held_request();
    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d mismatches, %0d other failures",
             check_count, mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 4;     // 8 ns clock.
  localparam int reset_cycles = 5;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule
